/* isa_pkg.sv */
package isa_pkg;

	// datapath and register file sizes
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int reg_count  = 32;

	// primary opcodes
	localparam logic [5:0] op_special = 6'b000000;
	localparam logic [5:0] op_j       = 6'b000010;
	localparam logic [5:0] op_beq     = 6'b000100;
	localparam logic [5:0] op_bne     = 6'b000101;
	localparam logic [5:0] op_addi    = 6'b001000;
	localparam logic [5:0] op_addiu   = 6'b001001;
	localparam logic [5:0] op_andi    = 6'b001100;
	localparam logic [5:0] op_ori     = 6'b001101;
	localparam logic [5:0] op_xori    = 6'b001110;
	localparam logic [5:0] op_lui     = 6'b001111;
	localparam logic [5:0] op_lw      = 6'b100011;
	localparam logic [5:0] op_sw      = 6'b101011;

	// funct field under op_special
	localparam logic [5:0] fn_sll  = 6'b000000;
	localparam logic [5:0] fn_srl  = 6'b000010;
	localparam logic [5:0] fn_sra  = 6'b000011;
	localparam logic [5:0] fn_sllv = 6'b000100;
	localparam logic [5:0] fn_add  = 6'b100000;
	localparam logic [5:0] fn_addu = 6'b100001;
	localparam logic [5:0] fn_sub  = 6'b100010;
	localparam logic [5:0] fn_subu = 6'b100011;
	localparam logic [5:0] fn_and  = 6'b100100;
	localparam logic [5:0] fn_or   = 6'b100101;
	localparam logic [5:0] fn_xor  = 6'b100110;
	localparam logic [5:0] fn_nor  = 6'b100111;
	localparam logic [5:0] fn_slt  = 6'b101010;
	localparam logic [5:0] fn_sltu = 6'b101011;

	typedef struct packed {
		logic [5:0]            opcode;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [reg_addr_w-1:0] rd;
		logic [4:0]            shamt;
		logic [5:0]            funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]            opcode;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [15:0]           imm16;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target26;
	} j_fmt_t;

	// same 32-bit word, three field layouts
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} inst_t;

endpackage

/* id_pkg.sv */
package id_pkg;

	import isa_pkg::*;

	typedef enum logic [7:0] {
		alu_nop   = 8'h00,
		alu_and   = 8'h01,
		alu_or    = 8'h02,
		alu_xor   = 8'h03,
		alu_nor   = 8'h04,
		alu_add   = 8'h05,
		alu_addu  = 8'h06,
		alu_sub   = 8'h07,
		alu_subu  = 8'h08,
		alu_slt   = 8'h09,
		alu_sltu  = 8'h0a,
		alu_sll   = 8'h0b,
		alu_srl   = 8'h0c,
		alu_sra   = 8'h0d,
		alu_sllv  = 8'h0e,
		alu_ori   = 8'h10,
		alu_andi  = 8'h11,
		alu_xori  = 8'h12,
		alu_lui   = 8'h13,
		alu_addi  = 8'h14,
		alu_addiu = 8'h15,
		alu_lw    = 8'h20,
		alu_sw    = 8'h21,
		alu_beq   = 8'h30,
		alu_bne   = 8'h31,
		alu_j     = 8'h32
	} alu_op_t;

	// how reg2 takes the immediate
	typedef enum logic [1:0] {
		imm_none,
		imm_zext,
		imm_sext,
		imm_lui_src
	} imm_kind_t;

	typedef enum logic [1:0] {
		br_none,
		br_eq,
		br_ne,
		br_jump
	} br_kind_t;

	typedef struct packed {
		logic                  rd1_en;
		logic                  rd2_en;
		logic [reg_addr_w-1:0] rd1_addr;
		logic [reg_addr_w-1:0] rd2_addr;
		alu_op_t               alu_op;
		imm_kind_t             imm_kind;
		logic [xlen-1:0]       imm;
		// reg1 comes from imm (shamt) instead of rs
		logic                  shamt_src;
		// reg1 is rs plus imm
		logic                  addr_calc;
		logic [reg_addr_w-1:0] dest;
		logic                  wreg;
		br_kind_t              br_kind;
	} decode_t;

	// result bus of a later stage, also the register file write port
	typedef struct packed {
		logic                  we;
		logic [reg_addr_w-1:0] addr;
		logic [xlen-1:0]       data;
	} fwd_t;

	typedef struct packed {
		alu_op_t               alu_op;
		logic [xlen-1:0]       reg1;
		logic [xlen-1:0]       reg2;
		logic [reg_addr_w-1:0] wd;
		logic                  wreg;
	} ex_req_t;

	typedef struct packed {
		logic            taken;
		logic [xlen-1:0] target;
	} branch_t;

endpackage

/* reg_file.sv */
module reg_file (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  logic [isa_pkg::reg_addr_w-1:0]   rd1_addr_i,
	input  logic [isa_pkg::reg_addr_w-1:0]   rd2_addr_i,
	input  id_pkg::fwd_t                     wb_i,
	output logic [isa_pkg::xlen-1:0]         rd1_data_o,
	output logic [isa_pkg::xlen-1:0]         rd2_data_o
);

	import isa_pkg::*;
	import id_pkg::*;

	// r0 has no storage
	logic [xlen-1:0] regs [1:reg_count-1];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 1; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.we && wb_i.addr != '0) begin
			regs[wb_i.addr] <= wb_i.data;
		end
	end

	// write in the same cycle shows up on the read port
	function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr,
	                                              input fwd_t wb);
		logic [xlen-1:0] val;
		if (addr == '0) begin
			val = '0;
		end else if (wb.we && wb.addr == addr) begin
			val = wb.data;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	assign rd1_data_o = read_port(rd1_addr_i, wb_i);
	assign rd2_data_o = read_port(rd2_addr_i, wb_i);

endmodule

/* inst_decoder.sv */
module inst_decoder (
	input  isa_pkg::inst_t   inst_i,
	output id_pkg::decode_t  dec_o
);

	import isa_pkg::*;
	import id_pkg::*;

	alu_op_t         r_op;
	logic            r_shift;
	alu_op_t         i_op;
	logic            i_sext;
	logic [xlen-1:0] imm_z;
	logic [xlen-1:0] imm_s;

	assign imm_z = {16'h0000, inst_i.i.imm16};
	assign imm_s = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};

	// funct lookup for the special group
	always_comb begin
		r_shift = 1'b0;
		case (inst_i.r.funct)
			fn_and:  r_op = alu_and;
			fn_or:   r_op = alu_or;
			fn_xor:  r_op = alu_xor;
			fn_nor:  r_op = alu_nor;
			fn_add:  r_op = alu_add;
			fn_addu: r_op = alu_addu;
			fn_sub:  r_op = alu_sub;
			fn_subu: r_op = alu_subu;
			fn_slt:  r_op = alu_slt;
			fn_sltu: r_op = alu_sltu;
			fn_sllv: r_op = alu_sllv;
			fn_sll, fn_srl, fn_sra: begin
				r_shift = 1'b1;
				r_op    = (inst_i.r.funct == fn_sll) ? alu_sll :
				          (inst_i.r.funct == fn_srl) ? alu_srl : alu_sra;
			end
			default: r_op = alu_nop;
		endcase
	end

	// opcode lookup for rs-plus-immediate forms
	always_comb begin
		i_sext = 1'b0;
		case (inst_i.i.opcode)
			op_ori:   i_op = alu_ori;
			op_andi:  i_op = alu_andi;
			op_xori:  i_op = alu_xori;
			op_addi:  i_op = alu_addi;
			op_addiu: i_op = alu_addiu;
			op_lw:    i_op = alu_lw;
			default:  i_op = alu_nop;
		endcase
		if (inst_i.i.opcode == op_addi || inst_i.i.opcode == op_addiu ||
		    inst_i.i.opcode == op_lw) begin
			i_sext = 1'b1;
		end
	end

	always_comb begin
		dec_o          = '0;
		dec_o.alu_op   = alu_nop;
		dec_o.imm_kind = imm_none;
		dec_o.br_kind  = br_none;
		case (inst_i.r.opcode)
			op_special: begin
				if (r_op != alu_nop) begin
					dec_o.rd1_en    = !r_shift;
					dec_o.rd1_addr  = r_shift ? '0 : inst_i.r.rs;
					dec_o.rd2_en    = 1'b1;
					dec_o.rd2_addr  = inst_i.r.rt;
					dec_o.alu_op    = r_op;
					dec_o.shamt_src = r_shift;
					dec_o.imm       = r_shift ? {27'b0, inst_i.r.shamt} : '0;
					dec_o.dest      = inst_i.r.rd;
					dec_o.wreg      = 1'b1;
				end
			end
			op_ori, op_andi, op_xori, op_addi, op_addiu, op_lw: begin
				dec_o.rd1_en   = 1'b1;
				dec_o.rd1_addr = inst_i.i.rs;
				dec_o.alu_op   = i_op;
				dec_o.imm_kind = i_sext ? imm_sext : imm_zext;
				dec_o.imm      = i_sext ? imm_s : imm_z;
				dec_o.dest     = inst_i.i.rt;
				dec_o.wreg     = 1'b1;
			end
			op_lui: begin
				dec_o.alu_op   = alu_lui;
				dec_o.imm_kind = imm_lui_src;
				dec_o.imm      = imm_z;
				dec_o.dest     = inst_i.i.rt;
				dec_o.wreg     = 1'b1;
			end
			op_sw: begin
				// address in reg1, store data from rt in reg2
				dec_o.rd1_en    = 1'b1;
				dec_o.rd1_addr  = inst_i.i.rs;
				dec_o.rd2_en    = 1'b1;
				dec_o.rd2_addr  = inst_i.i.rt;
				dec_o.alu_op    = alu_sw;
				dec_o.imm       = imm_s;
				dec_o.addr_calc = 1'b1;
			end
			op_beq, op_bne: begin
				dec_o.rd1_en   = 1'b1;
				dec_o.rd1_addr = inst_i.i.rs;
				dec_o.rd2_en   = 1'b1;
				dec_o.rd2_addr = inst_i.i.rt;
				dec_o.alu_op   = (inst_i.i.opcode == op_beq) ? alu_beq : alu_bne;
				dec_o.br_kind  = (inst_i.i.opcode == op_beq) ? br_eq : br_ne;
			end
			op_j: begin
				dec_o.alu_op  = alu_j;
				dec_o.br_kind = br_jump;
			end
			default: begin
				dec_o.alu_op = alu_nop;
			end
		endcase
		// writes to r0 are dropped, so sll r0 acts as a nop
		dec_o.wreg = dec_o.wreg && (dec_o.dest != '0);
	end

endmodule

/* operand_select.sv */
module operand_select (
	input  id_pkg::decode_t              dec_i,
	input  logic [isa_pkg::xlen-1:0]     rd1_data_i,
	input  logic [isa_pkg::xlen-1:0]     rd2_data_i,
	input  id_pkg::fwd_t                 ex_fwd_i,
	input  id_pkg::fwd_t                 mem_fwd_i,
	output logic [isa_pkg::xlen-1:0]     fwd1_o,
	output logic [isa_pkg::xlen-1:0]     fwd2_o,
	output id_pkg::ex_req_t              ex_req_o
);

	import isa_pkg::*;
	import id_pkg::*;

	// ex over mem over register file, r0 never forwarded
	function automatic logic [xlen-1:0] resolve(input logic en,
	                                            input logic [reg_addr_w-1:0] addr,
	                                            input logic [xlen-1:0] rf_data,
	                                            input fwd_t ex_fwd,
	                                            input fwd_t mem_fwd);
		logic [xlen-1:0] val;
		if (!en || addr == '0) begin
			val = '0;
		end else if (ex_fwd.we && ex_fwd.addr == addr) begin
			val = ex_fwd.data;
		end else if (mem_fwd.we && mem_fwd.addr == addr) begin
			val = mem_fwd.data;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	assign fwd1_o = resolve(dec_i.rd1_en, dec_i.rd1_addr, rd1_data_i, ex_fwd_i, mem_fwd_i);
	assign fwd2_o = resolve(dec_i.rd2_en, dec_i.rd2_addr, rd2_data_i, ex_fwd_i, mem_fwd_i);

	always_comb begin
		ex_req_o.alu_op = dec_i.alu_op;
		ex_req_o.wd     = dec_i.dest;
		ex_req_o.wreg   = dec_i.wreg;
		if (dec_i.shamt_src) begin
			ex_req_o.reg1 = dec_i.imm;
		end else if (dec_i.addr_calc) begin
			ex_req_o.reg1 = fwd1_o + dec_i.imm;
		end else begin
			ex_req_o.reg1 = fwd1_o;
		end
		case (dec_i.imm_kind)
			imm_zext, imm_sext: ex_req_o.reg2 = dec_i.imm;
			imm_lui_src:        ex_req_o.reg2 = {dec_i.imm[15:0], 16'h0000};
			default:            ex_req_o.reg2 = fwd2_o;
		endcase
	end

endmodule

/* branch_unit.sv */
module branch_unit (
	input  logic [isa_pkg::xlen-1:0]     pc_i,
	input  isa_pkg::inst_t               inst_i,
	input  id_pkg::br_kind_t             br_kind_i,
	input  logic [isa_pkg::xlen-1:0]     fwd1_i,
	input  logic [isa_pkg::xlen-1:0]     fwd2_i,
	output id_pkg::branch_t              branch_o
);

	import isa_pkg::*;
	import id_pkg::*;

	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] rel_target;
	logic [xlen-1:0] abs_target;

	assign pc_plus4   = pc_i + 32'd4;
	// word offset relative to the delay slot
	assign rel_target = pc_plus4 + {{14{inst_i.i.imm16[15]}}, inst_i.i.imm16, 2'b00};
	// jump stays inside the current 256 MB region
	assign abs_target = {pc_plus4[31:28], inst_i.j.target26, 2'b00};

	always_comb begin
		case (br_kind_i)
			br_eq:   branch_o.taken = (fwd1_i == fwd2_i);
			br_ne:   branch_o.taken = (fwd1_i != fwd2_i);
			br_jump: branch_o.taken = 1'b1;
			default: branch_o.taken = 1'b0;
		endcase
		if (!branch_o.taken) begin
			branch_o.target = '0;
		end else if (br_kind_i == br_jump) begin
			branch_o.target = abs_target;
		end else begin
			branch_o.target = rel_target;
		end
	end

endmodule

/* id_stage.sv */
module id_stage (
	input  logic                         clk,
	input  logic                         rst_n_i,
	input  logic [isa_pkg::xlen-1:0]     pc_i,
	input  isa_pkg::inst_t               inst_i,
	input  id_pkg::fwd_t                 ex_fwd_i,
	input  id_pkg::fwd_t                 mem_fwd_i,
	input  id_pkg::fwd_t                 wb_i,
	output id_pkg::ex_req_t              ex_req_o,
	output id_pkg::branch_t              branch_o
);

	import isa_pkg::*;
	import id_pkg::*;

	decode_t         dec;
	logic [xlen-1:0] rd1_data;
	logic [xlen-1:0] rd2_data;
	logic [xlen-1:0] fwd1;
	logic [xlen-1:0] fwd2;

	inst_decoder u_decoder (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	reg_file u_reg_file (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rd1_addr_i (dec.rd1_addr),
		.rd2_addr_i (dec.rd2_addr),
		.wb_i       (wb_i),
		.rd1_data_o (rd1_data),
		.rd2_data_o (rd2_data)
	);

	operand_select u_operand_select (
		.dec_i      (dec),
		.rd1_data_i (rd1_data),
		.rd2_data_i (rd2_data),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.fwd1_o     (fwd1),
		.fwd2_o     (fwd2),
		.ex_req_o   (ex_req_o)
	);

	// compares the forwarded operands, not the raw register file values
	branch_unit u_branch_unit (
		.pc_i      (pc_i),
		.inst_i    (inst_i),
		.br_kind_i (dec.br_kind),
		.fwd1_i    (fwd1),
		.fwd2_i    (fwd2),
		.branch_o  (branch_o)
	);

endmodule

/* id_stage_props.sv */
module id_stage_props (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  isa_pkg::inst_t                   inst_i,
	input  id_pkg::decode_t                  dec_i,
	input  logic [isa_pkg::xlen-1:0]         rd1_data_i,
	input  logic [isa_pkg::xlen-1:0]         rd2_data_i,
	input  id_pkg::ex_req_t                  ex_req_i,
	input  id_pkg::branch_t                  branch_i
);

	import isa_pkg::*;

	int fail_count = 0;

	function automatic logic known_op(input logic [5:0] op);
		return op == op_special || op == op_ori || op == op_andi || op == op_xori ||
		       op == op_lui || op == op_addi || op == op_addiu || op == op_lw ||
		       op == op_sw || op == op_beq || op == op_bne || op == op_j;
	endfunction

	// only the three control-flow opcodes may redirect
	taken_is_branch: assert property (@(posedge clk) disable iff (!rst_n_i)
		branch_i.taken |-> (inst_i.i.opcode == op_beq || inst_i.i.opcode == op_bne ||
		                    inst_i.i.opcode == op_j))
	else begin
		fail_count++;
		$error("branch taken for opcode %02h", inst_i.i.opcode);
	end

	unknown_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
		!known_op(inst_i.i.opcode) |-> !ex_req_i.wreg)
	else begin
		fail_count++;
		$error("write enabled for unknown opcode %02h", inst_i.i.opcode);
	end

	r0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
		(dec_i.rd1_addr != '0 || rd1_data_i == '0) &&
		(dec_i.rd2_addr != '0 || rd2_data_i == '0))
	else begin
		fail_count++;
		$error("register 0 read returned nonzero data");
	end

endmodule

bind id_stage id_stage_props props0 (
	.clk        (clk),
	.rst_n_i    (rst_n_i),
	.inst_i     (inst_i),
	.dec_i      (dec),
	.rd1_data_i (rd1_data),
	.rd2_data_i (rd2_data),
	.ex_req_i   (ex_req_o),
	.branch_i   (branch_o)
);

/* tb_id_stage.sv */
module tb_id_stage;

	import isa_pkg::*;
	import id_pkg::*;

	// about 880 cycles of stimulus, with margin
	localparam int max_cycles = 2000;

	logic            clk;
	logic            rst_n;
	logic [xlen-1:0] pc;
	inst_t           inst;
	fwd_t            ex_fwd;
	fwd_t            mem_fwd;
	fwd_t            wb;
	ex_req_t         ex_req;
	branch_t         branch;

	logic [xlen-1:0] shadow [0:reg_count-1];
	ex_req_t         exp_req;
	branch_t         exp_br;
	int              checks;
	int              errors;
	int              cycles;

	id_stage dut0 (
		.clk       (clk),
		.rst_n_i   (rst_n),
		.pc_i      (pc),
		.inst_i    (inst),
		.ex_fwd_i  (ex_fwd),
		.mem_fwd_i (mem_fwd),
		.wb_i      (wb),
		.ex_req_o  (ex_req),
		.branch_o  (branch)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// value decode should see for a source register
	function automatic logic [xlen-1:0] operand_value(input logic [reg_addr_w-1:0] a,
	                                                  input fwd_t ex, input fwd_t mem,
	                                                  input fwd_t wbw);
		if (a == '0) begin
			return '0;
		end
		if (ex.we && ex.addr == a) begin
			return ex.data;
		end
		if (mem.we && mem.addr == a) begin
			return mem.data;
		end
		if (wbw.we && wbw.addr == a) begin
			return wbw.data;
		end
		return shadow[a];
	endfunction

	function automatic void predict(input inst_t in, input logic [xlen-1:0] pc_v,
	                                input fwd_t ex, input fwd_t mem, input fwd_t wbw,
	                                output ex_req_t req, output branch_t br);
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] sext;
		logic [xlen-1:0] pc4;
		a = operand_value(in.i.rs, ex, mem, wbw);
		b = operand_value(in.i.rt, ex, mem, wbw);
		sext = {{16{in.i.imm16[15]}}, in.i.imm16};
		pc4 = pc_v + 32'd4;
		req = '0;
		br = '0;
		case (in.i.opcode)
			op_special: begin
				req.reg1 = a;
				req.reg2 = b;
				req.wd = in.r.rd;
				case (in.r.funct)
					fn_and:  req.alu_op = alu_and;
					fn_or:   req.alu_op = alu_or;
					fn_xor:  req.alu_op = alu_xor;
					fn_nor:  req.alu_op = alu_nor;
					fn_add:  req.alu_op = alu_add;
					fn_addu: req.alu_op = alu_addu;
					fn_sub:  req.alu_op = alu_sub;
					fn_subu: req.alu_op = alu_subu;
					fn_slt:  req.alu_op = alu_slt;
					fn_sltu: req.alu_op = alu_sltu;
					fn_sllv: req.alu_op = alu_sllv;
					fn_sll:  req.alu_op = alu_sll;
					fn_srl:  req.alu_op = alu_srl;
					fn_sra:  req.alu_op = alu_sra;
					default: req = '0;
				endcase
				// shifts take the shamt field instead of rs
				if (req.alu_op == alu_sll || req.alu_op == alu_srl || req.alu_op == alu_sra) begin
					req.reg1 = {27'd0, in.r.shamt};
				end
			end
			op_ori, op_andi, op_xori: begin
				req.alu_op = (in.i.opcode == op_ori) ? alu_ori :
				             (in.i.opcode == op_andi) ? alu_andi : alu_xori;
				req.reg1 = a;
				req.reg2 = {16'h0000, in.i.imm16};
				req.wd = in.i.rt;
			end
			op_addi, op_addiu, op_lw: begin
				req.alu_op = (in.i.opcode == op_addi) ? alu_addi :
				             (in.i.opcode == op_addiu) ? alu_addiu : alu_lw;
				req.reg1 = a;
				req.reg2 = sext;
				req.wd = in.i.rt;
			end
			op_lui: begin
				req.alu_op = alu_lui;
				req.reg2 = {in.i.imm16, 16'h0000};
				req.wd = in.i.rt;
			end
			op_sw: begin
				req.alu_op = alu_sw;
				req.reg1 = a + sext;
				req.reg2 = b;
			end
			op_beq, op_bne: begin
				req.alu_op = (in.i.opcode == op_beq) ? alu_beq : alu_bne;
				req.reg1 = a;
				req.reg2 = b;
				br.taken = (in.i.opcode == op_beq) ? (a == b) : (a != b);
				br.target = br.taken ? pc4 + {sext[29:0], 2'b00} : '0;
			end
			op_j: begin
				req.alu_op = alu_j;
				br.taken = 1'b1;
				br.target = {pc4[31:28], in.j.target26, 2'b00};
			end
			default: begin
				req = '0;
			end
		endcase
		req.wreg = (req.wd != '0);
	endfunction

	task automatic check_field(input string name, input logic [xlen-1:0] got,
	                           input logic [xlen-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %08h expected %08h (inst %08h)", name, got, exp, inst);
		end
	endtask

	// outputs are settled half a cycle after the inputs change
	always @(negedge clk) begin
		if (rst_n) begin
			predict(inst, pc, ex_fwd, mem_fwd, wb, exp_req, exp_br);
			check_field("ex_req_o.alu_op", 32'(ex_req.alu_op), 32'(exp_req.alu_op));
			check_field("ex_req_o.reg1", ex_req.reg1, exp_req.reg1);
			check_field("ex_req_o.reg2", ex_req.reg2, exp_req.reg2);
			check_field("ex_req_o.wd", 32'(ex_req.wd), 32'(exp_req.wd));
			check_field("ex_req_o.wreg", 32'(ex_req.wreg), 32'(exp_req.wreg));
			check_field("branch_o.taken", 32'(branch.taken), 32'(exp_br.taken));
			check_field("branch_o.target", branch.target, exp_br.target);
			if (wb.we && wb.addr != '0) begin
				shadow[wb.addr] = wb.data;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: stimulus did not finish within %0d cycles", max_cycles);
			$display("checks %0d, errors %0d", checks, errors + 1);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic drive(input inst_t in, input fwd_t ex, input fwd_t mem, input fwd_t wbw);
		@(posedge clk);
		inst <= in;
		pc <= $urandom & 32'hffff_fffc;
		ex_fwd <= ex;
		mem_fwd <= mem;
		wb <= wbw;
	endtask

	function automatic fwd_t make_fwd(input logic we, input logic [reg_addr_w-1:0] addr,
	                                  input logic [xlen-1:0] data);
		fwd_t f;
		f.we = we;
		f.addr = addr;
		f.data = data;
		return f;
	endfunction

	// biased toward the register being read
	function automatic fwd_t rand_fwd(input logic [reg_addr_w-1:0] near);
		logic [reg_addr_w-1:0] addr;
		addr = ($urandom % 2 == 1) ? near : 5'($urandom % reg_count);
		return make_fwd($urandom % 4 != 0, addr, $urandom);
	endfunction

	function automatic inst_t pick_inst();
		inst_t in;
		in = $urandom;
		case ($urandom % 6)
			0: in.r.opcode = op_special;
			1: in.i.opcode = op_ori;
			2: in.i.opcode = op_lw;
			3: in.i.opcode = op_sw;
			4: in.i.opcode = op_beq;
			default: in.i.opcode = op_bne;
		endcase
		if (in.r.opcode == op_special) begin
			in.r.funct = fn_subu;
		end
		// r0 as a source now and then
		if ($urandom % 8 == 0) begin
			in.i.rs = '0;
		end
		return in;
	endfunction

	initial begin
		inst_t           in;
		logic [xlen-1:0] d;
		rst_n = 1'b0;
		pc = '0;
		inst = '0;
		ex_fwd = '0;
		mem_fwd = '0;
		wb = '0;
		checks = 0;
		errors = 0;
		cycles = 0;
		for (int r = 0; r < reg_count; r++) begin
			shadow[r] = '0;
		end
		void'($urandom(32'ha43c));
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		for (int r = 1; r < reg_count; r++) begin
			drive('0, '0, '0, make_fwd(1'b1, 5'(r), $urandom));
		end
		// every funct code, kept and unsupported
		for (int f = 0; f < 64; f++) begin
			repeat (3) begin
				in = $urandom;
				in.r.opcode = op_special;
				in.r.funct = 6'(f);
				drive(in, '0, '0, '0);
			end
		end
		// every other opcode
		for (int op = 1; op < 64; op++) begin
			repeat (3) begin
				in = $urandom;
				in.i.opcode = 6'(op);
				drive(in, '0, '0, '0);
			end
		end
		// forwarding with same-cycle writes
		repeat (300) begin
			in = pick_inst();
			drive(in, rand_fwd(in.i.rs), rand_fwd(($urandom % 2 == 1) ? in.i.rs : in.i.rt),
			      rand_fwd(in.i.rt));
		end
		repeat (150) begin
			in = $urandom;
			in.i.opcode = ($urandom % 3 == 0) ? op_j : (($urandom % 2 == 1) ? op_beq : op_bne);
			if ($urandom % 2 == 1) begin
				in.i.rt = in.i.rs;
			end
			d = $urandom;
			// equal values arriving through both forwarding paths
			if ($urandom % 3 == 0) begin
				drive(in, make_fwd(1'b1, in.i.rs, d), make_fwd(1'b1, in.i.rt, d), '0);
			end else begin
				drive(in, rand_fwd(in.i.rs), rand_fwd(in.i.rt), '0);
			end
		end

		// last vector is sampled by the assertions on the next rising edge
		@(posedge clk);
		#1;
		errors = errors + dut0.props0.fail_count;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* id_stage.f */
isa_pkg.sv
id_pkg.sv
reg_file.sv
inst_decoder.sv
operand_select.sv
branch_unit.sv
id_stage.sv
id_stage_props.sv
tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - isa_pkg.sv
  - id_pkg.sv
  - reg_file.sv
  - inst_decoder.sv
  - operand_select.sv
  - branch_unit.sv
  - id_stage.sv
  - target: test
    files:
      - id_stage_props.sv
      - tb_id_stage.sv
